/* Makefile */
VERILATOR ?= verilator
TOP       ?= upSystemTb
LINT_TOP  ?= upSystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

/* bench/upSystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module upSystemTb import upPkg::*; ();

	typedef struct {
		logic [0:15][7:0] prog; // byte 0 sits in the top bits.
		int               count;
		bit               useBoot;
		logic [7:0]       acc;
		logic             zero;
		logic             carry;
		logic [7:0]       probe;
	} testT;

	logic        clk = 1'b0;
	logic        nRst;
	logic        start;
	logic        loadEn;
	logic [7:0]  loadAddr;
	logic [7:0]  loadData;
	logic        running;
	logic        halted;
	logic [7:0]  acc;
	logic        zero;
	logic        carry;
	logic [7:0]  probe;
	testT        tests[$];
	logic [7:0]  refMem [256];
	logic [31:0] lfsr = 32'h64d9_d572;
	int          cycles = 0;
	int          cycleLimit = 0;

	upSystem #(.probeAddr(8'd127)) dut0 (
		.clk, .nRst, .start, .loadEn, .loadAddr, .loadData,
		.running, .halted, .acc, .zero, .carry, .probe
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// taps at bits 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randByte(output logic [7:0] v);
		v = 8'h00;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	// the result is in bits 7:0 and the carry or borrow in bit 8.
	function automatic logic [8:0] aluModel(input aluOpT op, input logic [7:0] a,
			input logic [7:0] b);
		case (op)
			aluAdd: return {(int'(a) + int'(b)) > 255, a + b};
			aluSub: return {a < b, a - b};
			aluAnd: return {1'b0, a & b};
			aluOr: return {1'b0, a | b};
			aluXor: return {1'b0, a ^ b};
			aluShl: return {a[7], a[6:0], 1'b0};
			aluShr: return {a[0], a >> 1};
			default: return {1'b0, b};
		endcase
	endfunction

	// Executes refMem from address 0 one whole instruction at a time.
	task automatic runModel(inout testT t);
		logic [7:0] pc;
		logic [7:0] opnd;
		logic [7:0] b;
		logic [8:0] res;
		logic [3:0] opcode;
		instrT      ins;
		aluOpT      op;
		bit         load;
		bit         done;
		pc = 8'h00;
		t.acc = 8'h00;
		t.zero = 1'b0;
		t.carry = 1'b0;
		done = 1'b0;
		for (int step = 0; step < 100 && !done; step++) begin
			ins = refMem[pc];
			opcode = ins.immView.opcode;
			pc++;
			opnd = 8'h00;
			if (opcode >= opLda && opcode <= opJmp) begin
				opnd = refMem[pc];
				pc++;
			end
			load = 1'b1;
			op = aluPassB;
			b = refMem[opnd];
			case (opcode)
				opLda: op = aluPassB;
				opAdd: op = aluAdd;
				opSub: op = aluSub;
				opAnd: op = aluAnd;
				opOr: op = aluOr;
				opXor: op = aluXor;
				opShl: op = aluShl;
				opShr: op = aluShr;
				opLdi: b = {4'h0, ins.immView.imm};
				default: load = 1'b0;
			endcase
			if (opcode == opJmp) begin
				case ({ins.condView.rsvd, ins.condView.cond})
					4'd0: pc = opnd;
					4'd1: if (t.zero) pc = opnd;
					4'd2: if (t.carry) pc = opnd;
					4'd3: if (!t.zero) pc = opnd;
					default: ; // codes 4 to 15 fall through.
				endcase
			end
			if (load) begin
				res = aluModel(op, t.acc, b);
				t.acc = res[7:0];
				t.zero = (res[7:0] == 8'h00);
				t.carry = res[8];
			end
			if (opcode == opSta) refMem[opnd] = t.acc;
			if (opcode == opHlt) done = 1'b1;
		end
		if (!done) begin
			$display("reference model: a table program never reached HLT");
			$display("Simulation failed");
			$fatal(1, "broken test table");
		end
		t.probe = refMem[127];
	endtask

	// memory starts as it is after reset, then the program overwrites its low bytes.
	task automatic addTest(input logic [0:15][7:0] prog, input int count, input bit useBoot);
		testT t;
		t.prog = prog;
		t.count = count;
		t.useBoot = useBoot;
		for (int i = 0; i < 256; i++) begin
			if (i < 16) refMem[i] = bootImage[i];
			else refMem[i] = 8'h00;
		end
		if (useBoot) begin
			// the boot program adds 5 to 0x37 and stores the sum at 127.
			t.acc = 8'h3C;
			t.zero = 1'b0;
			t.carry = 1'b0;
			t.probe = 8'h3C;
		end else begin
			for (int i = 0; i < count; i++) refMem[i] = prog[i];
			runModel(t);
		end
		tests.push_back(t);
	endtask

	task automatic checkByte(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected 0x%02h, got 0x%02h",
				$time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic runTest(input testT t, input int n);
		@(posedge clk);
		nRst <= 1'b0;
		repeat (5) @(posedge clk);
		nRst <= 1'b1;
		if (!t.useBoot) begin
			for (int i = 0; i < t.count; i++) begin
				@(posedge clk);
				loadEn   <= 1'b1;
				loadAddr <= 8'(i);
				loadData <= t.prog[i];
			end
		end
		@(posedge clk);
		loadEn <= 1'b0;
		start  <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		do @(negedge clk); while (!halted);
		checkByte($sformatf("test %0d acc", n), acc, t.acc);
		checkFlag($sformatf("test %0d zero", n), zero, t.zero);
		checkFlag($sformatf("test %0d carry", n), carry, t.carry);
		checkByte($sformatf("test %0d probe", n), probe, t.probe);
		checkFlag($sformatf("test %0d running", n), running, 1'b0);
	endtask

	initial begin
		logic [0:15][7:0] prog;
		logic [7:0]       a;
		logic [7:0]       b;
		nRst     = 1'b0;
		start    = 1'b0;
		loadEn   = 1'b0;
		loadAddr = 8'h00;
		loadData = 8'h00;
		addTest('0, 0, 1'b1); // boot image straight after reset.
		addTest(128'h100E_300F_207F_F000_0000_0000_0000_C850, 16, 1'b0);
		addTest(128'h100E_300F_207F_F000_0000_0000_0000_8080, 16, 1'b0);
		addTest(128'h100E_400F_207F_F000_0000_0000_0000_2030, 16, 1'b0);
		addTest(128'h100E_400F_207F_F000_0000_0000_0000_5555, 16, 1'b0);
		addTest(128'h100E_500F_207F_F000_0000_0000_0000_F03C, 16, 1'b0);
		addTest(128'h100E_600F_207F_F000_0000_0000_0000_C30F, 16, 1'b0);
		addTest(128'h100E_700F_207F_F000_0000_0000_0000_5A5A, 16, 1'b0);
		addTest(128'h100E_C020_7FF0_0000_0000_0000_0000_8100, 16, 1'b0);
		addTest(128'h100E_D020_7FF0_0000_0000_0000_0000_8100, 16, 1'b0);
		addTest(128'h100E_D020_7FF0_0000_0000_0000_0000_0100, 16, 1'b0);
		// marker 2 at 127 means the branch was taken, marker 1 that it fell through.
		addTest(128'hB300_8008_B120_7FF0_B220_7FF0_0000_0000, 12, 1'b0);
		addTest(128'hB000_8108_B120_7FF0_B220_7FF0_0000_0000, 12, 1'b0);
		addTest(128'hB300_8108_B120_7FF0_B220_7FF0_0000_0000, 12, 1'b0);
		addTest(128'h4007_8208_B120_7FF0_B220_7FF0_0000_0000, 12, 1'b0);
		addTest(128'hB300_8208_B120_7FF0_B220_7FF0_0000_0000, 12, 1'b0);
		addTest(128'hB300_8308_B120_7FF0_B220_7FF0_0000_0000, 12, 1'b0);
		addTest(128'hB000_8308_B120_7FF0_B220_7FF0_0000_0000, 12, 1'b0);
		addTest(128'hB300_8408_B120_7FF0_B220_7FF0_0000_0000, 12, 1'b0);
		addTest(128'h100E_207F_F000_0000_0000_0000_0000_A500, 16, 1'b0);
		addTest('0, 0, 1'b1);
		for (int i = 0; i < 6; i++) begin
			randByte(a);
			randByte(b);
			prog = 128'h100E_300F_207F_F000_0000_0000_0000_0000;
			if (i % 2 == 1) prog[2] = {opSub, 4'h0};
			prog[14] = a;
			prog[15] = b;
			addTest(prog, 16, 1'b0);
		end
		cycleLimit = (tests.size() + 1) * (16 + 3 * 16 + 10);
		foreach (tests[n]) runTest(tests[n], n);
		for (int i = 0; i < 4; i++) begin
			randByte(a);
			@(posedge clk);
			loadEn   <= 1'b1;
			loadAddr <= 8'd127;
			loadData <= a;
			@(posedge clk);
			loadEn <= 1'b0;
			@(negedge clk);
			checkByte("probe after host write", probe, a);
			checkFlag("halted during host write", halted, 1'b1);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* common/upPkg.sv */
`default_nettype none

package upPkg;

	localparam logic [3:0] opNop = 4'h0;
	localparam logic [3:0] opLda = 4'h1;
	localparam logic [3:0] opSta = 4'h2;
	localparam logic [3:0] opAdd = 4'h3;
	localparam logic [3:0] opSub = 4'h4;
	localparam logic [3:0] opAnd = 4'h5;
	localparam logic [3:0] opOr  = 4'h6;
	localparam logic [3:0] opXor = 4'h7;
	localparam logic [3:0] opJmp = 4'h8;
	localparam logic [3:0] opLdi = 4'hB;
	localparam logic [3:0] opShl = 4'hC;
	localparam logic [3:0] opShr = 4'hD;
	localparam logic [3:0] opHlt = 4'hF;

	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] imm; // zero-extended by the datapath.
	} immViewT;

	// low nibble 0 to 3 picks the condition, anything higher never jumps.
	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rsvd;
		logic [1:0] cond;
	} condViewT;

	typedef union packed {
		immViewT  immView;
		condViewT condView;
	} instrT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluShl,
		aluShr,
		aluPassB
	} aluOpT;

	// byte i of the image lands at address i.
	localparam logic [15:0][7:0] bootImage = {
		8'h37, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'hF0, 8'h7F, 8'h20, 8'h0F, 8'h30, 8'hB5
	};

endpackage

`default_nettype wire

/* flist.f */
common/upPkg.sv
memory/upMemory.sv
logic/upAlu.sv
logic/upRegs.sv
logic/upControl.sv
logic/upSystem.sv
bench/upSystemTb.sv

/* logic/upAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module upAlu import upPkg::*; (
	input  wire aluOpT op,
	input  wire  [7:0] a,
	input  wire  [7:0] b,
	output logic [7:0] y,
	output logic       carry,
	output logic       zero
);

	logic [8:0] wide; // bit 8 is the carry out.

	always_comb begin
		wide = 9'h000;
		case (op)
			aluAdd: wide = {1'b0, a} + {1'b0, b};
			// the ninth bit of the difference is the borrow.
			aluSub: wide = {1'b0, a} - {1'b0, b};
			aluAnd: wide = {1'b0, a & b};
			aluOr: wide = {1'b0, a | b};
			aluXor: wide = {1'b0, a ^ b};
			aluShl: wide = {a, 1'b0};
			aluShr: wide = {a[0], 1'b0, a[7:1]}; // lsb falls out into carry.
			aluPassB: wide = {1'b0, b};
			default: wide = 9'h000;
		endcase
	end

	assign y     = wide[7:0];
	assign carry = wide[8];
	assign zero  = (wide[7:0] == 8'h00);

endmodule

`default_nettype wire

/* logic/upControl.sv */
`timescale 1ns/1ps
`default_nettype none

module upControl import upPkg::*; (
	input  wire        clk,
	input  wire        nRst,
	input  wire        start,
	input  wire instrT ir,
	input  wire        zero,
	input  wire        carry,
	output logic       running,
	output logic       halted,
	output logic       pcClear,
	output logic       pcInc,
	output logic       pcJump,
	output logic       irLoad,
	output logic       operandLoad,
	output logic       addrFromOperand,
	output logic       bFromImm,
	output logic       accLoad,
	output logic       memWrite,
	output aluOpT      aluOp
);

	typedef enum logic [2:0] {
		sIdle,
		sFetch,
		sOperand,
		sExecute,
		sHalt
	} stateT;

	stateT      state;
	stateT      nextState;
	logic [3:0] opcode;
	logic       hasOperand;
	logic       execNow;
	logic       jumpTaken;

	assign opcode     = ir.immView.opcode;
	assign hasOperand = (opcode >= opLda) && (opcode <= opJmp);

	// one-byte instructions execute in the cycle after fetch, where ir is first valid.
	assign execNow = (state == sExecute) || (state == sOperand && !hasOperand);

	always_comb begin
		jumpTaken = 1'b0;
		if (ir.condView.rsvd == 2'b00) begin
			case (ir.condView.cond)
				2'd0: jumpTaken = 1'b1;
				2'd1: jumpTaken = zero;
				2'd2: jumpTaken = carry;
				2'd3: jumpTaken = !zero;
				default: jumpTaken = 1'b0;
			endcase
		end
	end

	always_comb begin
		case (opcode)
			opAdd: aluOp = aluAdd;
			opSub: aluOp = aluSub;
			opAnd: aluOp = aluAnd;
			opOr: aluOp = aluOr;
			opXor: aluOp = aluXor;
			opShl: aluOp = aluShl;
			opShr: aluOp = aluShr;
			default: aluOp = aluPassB; // LDA and LDI just move b through.
		endcase
	end

	always_comb begin
		nextState   = state;
		pcClear     = 1'b0;
		pcInc       = 1'b0;
		irLoad      = 1'b0;
		operandLoad = 1'b0;
		case (state)
			sIdle, sHalt: if (start) begin
				pcClear   = 1'b1;
				nextState = sFetch;
			end
			sFetch: begin
				irLoad    = 1'b1;
				pcInc     = 1'b1;
				nextState = sOperand;
			end
			sOperand: if (hasOperand) begin
				operandLoad = 1'b1;
				pcInc       = 1'b1;
				nextState   = sExecute;
			end else begin
				nextState = (opcode == opHlt) ? sHalt : sFetch;
			end
			sExecute: nextState = (opcode == opHlt) ? sHalt : sFetch;
			default: nextState = sIdle;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) state <= sIdle;
		else state <= nextState;
	end

	assign running         = (state == sFetch) || (state == sOperand) || (state == sExecute);
	assign halted          = (state == sHalt);
	assign addrFromOperand = (state == sExecute);
	assign bFromImm        = execNow && (opcode == opLdi);
	assign memWrite        = execNow && (opcode == opSta);
	assign pcJump          = execNow && (opcode == opJmp) && jumpTaken;

	always_comb begin
		accLoad = 1'b0;
		if (execNow) begin
			case (opcode)
				opLda, opAdd, opSub, opAnd, opOr, opXor, opLdi, opShl, opShr: accLoad = 1'b1;
				default: accLoad = 1'b0; // NOP, STA, JMP, HLT and undefined codes.
			endcase
		end
	end

	legalState: assert property (@(posedge clk) disable iff (!nRst)
		state inside {sIdle, sFetch, sOperand, sExecute, sHalt});

endmodule

`default_nettype wire

/* logic/upRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module upRegs import upPkg::*; (
	input  wire        clk,
	input  wire        nRst,
	input  wire  [7:0] rdData,
	input  wire        pcClear,
	input  wire        pcInc,
	input  wire        pcJump,
	input  wire        irLoad,
	input  wire        operandLoad,
	input  wire        addrFromOperand,
	input  wire        bFromImm,
	input  wire        accLoad,
	input  wire  [7:0] aluY,
	input  wire        aluCarry,
	input  wire        aluZero,
	output instrT      ir,
	output logic [7:0] memAddr,
	output logic [7:0] accOut,
	output logic [7:0] aluA,
	output logic [7:0] aluB,
	output logic       zero,
	output logic       carry
);

	logic [7:0] pc;
	logic [7:0] operand;
	logic [7:0] acc;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= 8'h00;
		end else if (pcClear) begin
			pc <= 8'h00;
		end else if (pcJump) begin
			pc <= operand;
		end else if (pcInc) begin
			pc <= pc + 8'd1; // wraps at the top of memory.
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			ir    <= '0;
			acc   <= 8'h00;
			zero  <= 1'b0;
			carry <= 1'b0;
		end else begin
			if (irLoad) ir <= rdData;
			if (accLoad) begin
				acc   <= aluY;
				zero  <= aluZero;
				carry <= aluCarry;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (operandLoad) operand <= rdData;
	end

	assign memAddr = addrFromOperand ? operand : pc;
	assign accOut  = acc;
	assign aluA    = acc;
	assign aluB    = bFromImm ? {4'h0, ir.immView.imm} : rdData;

	// the control unit never advances and branches in the same cycle.
	pcSingleUpdate: assert property (@(posedge clk) disable iff (!nRst)
		!(pcInc && pcJump));

endmodule

`default_nettype wire

/* logic/upSystem.sv */
`timescale 1ns/1ps
`default_nettype none

module upSystem import upPkg::*; #(
	parameter logic [7:0] probeAddr = 8'd127
) (
	input  wire        clk,
	input  wire        nRst,
	input  wire        start,
	input  wire        loadEn,
	input  wire  [7:0] loadAddr,
	input  wire  [7:0] loadData,
	output logic       running,
	output logic       halted,
	output logic [7:0] acc,
	output logic       zero,
	output logic       carry,
	output logic [7:0] probe
);

	instrT      ir;
	aluOpT      aluOp;
	logic       pcClear, pcInc, pcJump, irLoad, operandLoad;
	logic       addrFromOperand, bFromImm, accLoad, memWrite;
	logic [7:0] memAddr, rdData;
	logic [7:0] aluA, aluB, aluY;
	logic       aluCarry, aluZero;

	upControl control0 (
		.clk, .nRst, .start, .ir, .zero, .carry,
		.running, .halted, .pcClear, .pcInc, .pcJump, .irLoad, .operandLoad,
		.addrFromOperand, .bFromImm, .accLoad, .memWrite, .aluOp
	);

	upRegs regs0 (
		.clk, .nRst, .rdData, .pcClear, .pcInc, .pcJump, .irLoad, .operandLoad,
		.addrFromOperand, .bFromImm, .accLoad, .aluY, .aluCarry, .aluZero,
		.ir, .memAddr, .accOut(acc), .aluA, .aluB, .zero, .carry
	);

	upAlu alu0 (
		.op(aluOp), .a(aluA), .b(aluB),
		.y(aluY), .carry(aluCarry), .zero(aluZero)
	);

	// stores always take the accumulator.
	upMemory #(.probeAddr(probeAddr)) memory0 (
		.clk, .nRst, .running,
		.cpuAddr(memAddr), .cpuData(acc), .cpuWrite(memWrite),
		.loadEn, .loadAddr, .loadData,
		.rdData, .probe
	);

endmodule

`default_nettype wire

/* memory/upMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module upMemory import upPkg::*; #(
	parameter logic [7:0] probeAddr = 8'd127
) (
	input  wire        clk,
	input  wire        nRst,
	input  wire        running,
	input  wire  [7:0] cpuAddr,
	input  wire  [7:0] cpuData,
	input  wire        cpuWrite,
	input  wire        loadEn,
	input  wire  [7:0] loadAddr,
	input  wire  [7:0] loadData,
	output logic [7:0] rdData,
	output logic [7:0] probe
);

	logic [7:0] mem [256];
	logic [7:0] wrAddr;
	logic [7:0] wrData;
	logic       wrEn;

	// the host owns the write port whenever the processor is stopped.
	always_comb begin
		if (running) begin
			wrEn   = cpuWrite;
			wrAddr = cpuAddr;
			wrData = cpuData;
		end else begin
			wrEn   = loadEn;
			wrAddr = loadAddr;
			wrData = loadData;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < 16; i++) mem[i] <= bootImage[i];
			for (int i = 16; i < 256; i++) mem[i] <= 8'h00;
		end else if (wrEn) begin
			mem[wrAddr] <= wrData;
		end
	end

	assign rdData = mem[cpuAddr];
	assign probe  = mem[probeAddr]; // always visible, no read strobe.

	// a processor store only happens inside a running program.
	cpuWriteOnlyRunning: assert property (@(posedge clk) disable iff (!nRst)
		cpuWrite |-> running);

endmodule

`default_nettype wire
